/* Bender.yml */
package:
  name: npc

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/npc_pkg.sv
      - src/npc_alu.sv
      - src/npc_decode.sv
      - src/npc_dmem.sv
      - src/npc_regfile.sv
      - src/npc_fetch.sv
      - src/npc_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_npc.sv

/* dv/tb_npc.sv */
`timescale 1ns/1ps
`include "npc_macros.svh"

module tb_npc;
  import npc_pkg::*;

  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_SYSTEM = 7'h73;

  logic    clk;
  logic    rst;
  word_t   imem_addr;
  word_t   imem_data;
  logic    retire_valid;
  retire_t retire;
  logic    halt;

  retire_t rows[$];  // expected retires in order
  word_t   cur_pc;
  word_t   rnd;
  int      errors;
  int      idx;

  npc_core dut_i (
    .clk         (clk),
    .rst         (rst),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .retire_valid(retire_valid),
    .retire      (retire),
    .halt        (halt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic word_t r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                   logic [6:0] opc);
    return {imm, rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, int rd);
    return {imm, rd[4:0], OPC_LUI};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic add_row(word_t inst, logic wen, int rd, word_t data, word_t next);
    retire_t r;
    r.pc      = cur_pc;
    r.inst    = inst;
    r.rd_wen  = wen;
    r.rd      = rd[4:0];
    r.rd_data = data;
    r.next_pc = next;
    rows.push_back(r);
    cur_pc = next;
  endtask

  task automatic seq_row(word_t inst, logic wen, int rd, word_t data);
    add_row(inst, wen, rd, data, cur_pc + 32'd4);
  endtask

  task automatic build_program();
    word_t       b;
    word_t       ecall_pc;
    logic [19:0] hi;
    b      = `NPC_RESET_PC;
    cur_pc = b;
    hi     = 20'((rnd + 32'h800) >> 12);  // rounds for the signed addi low part
    seq_row(u_type(20'h12345, 1), 1'b1, 1, 32'h1234_5000);
    seq_row(i_type(12'h678, 1, 3'b000, 2, OPC_OP_IMM), 1'b1, 2, 32'h1234_5678);
    seq_row(i_type(12'hffb, 0, 3'b000, 3, OPC_OP_IMM), 1'b1, 3, 32'hffff_fffb);
    seq_row(r_type(7'h00, 3, 2, 3'b000, 4), 1'b1, 4, 32'h1234_5673);
    seq_row(r_type(7'h20, 2, 3, 3'b000, 5), 1'b1, 5, 32'hedcb_a983);  // sub
    seq_row(i_type(12'h004, 2, 3'b001, 6, OPC_OP_IMM), 1'b1, 6, 32'h2345_6780);
    seq_row(i_type(12'h401, 3, 3'b101, 7, OPC_OP_IMM), 1'b1, 7, 32'hffff_fffd);  // srai
    seq_row(i_type(12'h01c, 3, 3'b101, 8, OPC_OP_IMM), 1'b1, 8, 32'h0000_000f);
    seq_row(r_type(7'h00, 2, 3, 3'b010, 9), 1'b1, 9, 32'd1);
    seq_row(r_type(7'h00, 2, 3, 3'b011, 10), 1'b1, 10, 32'd0);
    seq_row(b_type(13'd8, 10, 9, 3'b000), 1'b0, 0, 32'd0);  // beq not taken
    add_row(b_type(13'd8, 10, 9, 3'b001), 1'b0, 0, 32'd0, cur_pc + 32'd8);
    add_row(b_type(13'd8, 2, 3, 3'b100), 1'b0, 0, 32'd0, cur_pc + 32'd8);
    add_row(b_type(13'd8, 2, 3, 3'b111), 1'b0, 0, 32'd0, cur_pc + 32'd8);
    add_row(j_type(21'd12, 11), 1'b1, 11, cur_pc + 32'd4, cur_pc + 32'd12);
    add_row(i_type(12'd16, 11, 3'b000, 12, OPC_JALR), 1'b1, 12, cur_pc + 32'd4, b + 32'h58);
    add_row(b_type(13'd8, 3, 2, 3'b110), 1'b0, 0, 32'd0, cur_pc + 32'd8);
    // sized stores and loads
    seq_row(s_type(12'd16, 5, 0, 3'b010), 1'b0, 0, 32'd0);
    seq_row(i_type(12'd16, 0, 3'b000, 13, OPC_LOAD), 1'b1, 13, 32'hffff_ff83);
    seq_row(i_type(12'd17, 0, 3'b100, 14, OPC_LOAD), 1'b1, 14, 32'h0000_00a9);
    seq_row(i_type(12'd18, 0, 3'b001, 15, OPC_LOAD), 1'b1, 15, 32'hffff_edcb);
    seq_row(s_type(12'd20, 2, 0, 3'b000), 1'b0, 0, 32'd0);
    seq_row(s_type(12'd22, 2, 0, 3'b001), 1'b0, 0, 32'd0);
    seq_row(i_type(12'd22, 0, 3'b101, 16, OPC_LOAD), 1'b1, 16, 32'h0000_5678);
    seq_row(i_type(12'd20, 0, 3'b100, 17, OPC_LOAD), 1'b1, 17, 32'h0000_0078);
    seq_row(u_type(hi, 18), 1'b1, 18, {hi, 12'h000});
    seq_row(i_type(rnd[11:0], 18, 3'b000, 18, OPC_OP_IMM), 1'b1, 18, rnd);
    seq_row(s_type(12'd32, 18, 0, 3'b010), 1'b0, 0, 32'd0);
    seq_row(i_type(12'd33, 0, 3'b000, 19, OPC_LOAD), 1'b1, 19, {{24{rnd[15]}}, rnd[15:8]});
    seq_row(i_type(12'd34, 0, 3'b101, 20, OPC_LOAD), 1'b1, 20, {16'h0000, rnd[31:16]});
    // csr access and trap round trip
    seq_row(u_type(b[31:12], 22), 1'b1, 22, {b[31:12], 12'h000});
    seq_row(i_type(12'h200, 22, 3'b000, 22, OPC_OP_IMM), 1'b1, 22, b + 32'h200);
    seq_row(i_type(`NPC_CSR_MTVEC, 22, 3'b001, 21, OPC_SYSTEM), 1'b1, 21, 32'd0);
    seq_row(i_type(12'h100, 0, 3'b000, 24, OPC_OP_IMM), 1'b1, 24, 32'h0000_0100);
    seq_row(i_type(`NPC_CSR_MTVEC, 24, 3'b010, 23, OPC_SYSTEM), 1'b1, 23, b + 32'h200);
    seq_row(i_type(`NPC_CSR_MTVEC, 0, 3'b010, 25, OPC_SYSTEM), 1'b1, 25, b + 32'h300);
    seq_row(i_type(12'h200, 22, 3'b000, 29, OPC_OP_IMM), 1'b1, 29, b + 32'h400);
    ecall_pc = cur_pc;
    add_row(32'h0000_0073, 1'b0, 0, 32'd0, b + 32'h300);
    seq_row(i_type(`NPC_CSR_MCAUSE, 0, 3'b010, 26, OPC_SYSTEM), 1'b1, 26, 32'd11);
    seq_row(i_type(`NPC_CSR_MEPC, 0, 3'b010, 27, OPC_SYSTEM), 1'b1, 27, ecall_pc);
    seq_row(i_type(`NPC_CSR_MTVEC, 29, 3'b001, 28, OPC_SYSTEM), 1'b1, 28, b + 32'h300);
    add_row(32'h3020_0073, 1'b0, 0, 32'd0, ecall_pc);  // mret
    add_row(32'h0000_0073, 1'b0, 0, 32'd0, b + 32'h400);  // second handler this time
    seq_row(i_type(12'd5, 0, 3'b000, 0, OPC_OP_IMM), 1'b1, 0, 32'd5);
    seq_row(r_type(7'h00, 9, 0, 3'b000, 30), 1'b1, 30, 32'd1);  // x0 still zero
    seq_row(32'h0010_0073, 1'b0, 0, 32'd0);  // ebreak
  endtask

  function automatic word_t program_word(word_t addr);
    foreach (rows[i]) begin
      if (rows[i].pc == addr) return rows[i].inst;
    end
    return (addr * 32'h9e37_79b9) | 32'h0000_007f;  // unused opcode, address hash
  endfunction

  task automatic flag_mismatch(string field, word_t got, word_t exp);
    errors++;
    $display("[FAIL] %0t ns: %s is %h, expected %h", $time, field, got, exp);
    $display("Test FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_retire(retire_t exp);
    assert (imem_addr == exp.pc) else flag_mismatch("imem_addr", imem_addr, exp.pc);
    assert (retire.pc == exp.pc) else flag_mismatch("pc", retire.pc, exp.pc);
    assert (retire.inst == exp.inst) else flag_mismatch("inst", retire.inst, exp.inst);
    assert (retire.rd_wen == exp.rd_wen)
      else flag_mismatch("rd_wen", 32'(retire.rd_wen), 32'(exp.rd_wen));
    if (exp.rd_wen) begin
      assert (retire.rd == exp.rd) else flag_mismatch("rd", 32'(retire.rd), 32'(exp.rd));
      if (exp.rd != '0) begin
        assert (retire.rd_data == exp.rd_data)
          else flag_mismatch("rd_data", retire.rd_data, exp.rd_data);
      end
    end
    assert (retire.next_pc == exp.next_pc)
      else flag_mismatch("next_pc", retire.next_pc, exp.next_pc);
  endtask

  // present the word the pc moves to at this edge
  always @(posedge clk) begin
    if (rst) imem_data <= program_word(`NPC_RESET_PC);
    else if (halt) imem_data <= program_word(imem_addr);
    else imem_data <= program_word(retire.next_pc);
  end

  initial begin
    rst       = 1'b1;
    imem_data = '0;
    errors    = 0;
    rnd       = $urandom(32'hb7cc_8e86);
    rnd       = $urandom();
    build_program();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

  initial begin
    wait (rows.size() > 0);
    repeat (rows.size() + 20) @(posedge clk);
    $display("timeout: the core did not retire the whole program and halt in time");
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    idx = 0;
    wait (rows.size() > 0);
    while (idx < rows.size()) begin
      @(negedge clk);
      if (retire_valid) begin
        check_retire(rows[idx]);
        idx++;
      end
    end
    repeat (4) begin
      @(negedge clk);
      assert (halt) else flag_mismatch("halt", 32'(halt), 32'd1);
      assert (!retire_valid) else flag_mismatch("retire_valid", 32'(retire_valid), 32'd0);
      assert (imem_addr == rows[rows.size() - 1].next_pc)  // pc frozen after ebreak
        else flag_mismatch("imem_addr", imem_addr, rows[rows.size() - 1].next_pc);
    end
    if (errors == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Test FAILED");
      $fatal(1, "checks failed");
    end
  end

endmodule

/* filelist.f */
+incdir+src
src/npc_pkg.sv
src/npc_alu.sv
src/npc_decode.sv
src/npc_dmem.sv
src/npc_regfile.sv
src/npc_fetch.sv
src/npc_core.sv
dv/tb_npc.sv

/* src/npc_alu.sv */
`timescale 1ns/1ps

module npc_alu (
  input  npc_pkg::alu_op_e op,
  input  npc_pkg::word_t   a,
  input  npc_pkg::word_t   b,
  output npc_pkg::word_t   y
);
  import npc_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_SLL:  y = a << shamt;
      ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: y = {31'b0, a < b};
      ALU_XOR:  y = a ^ b;
      ALU_SRL:  y = a >> shamt;
      ALU_SRA:  y = word_t'($signed(a) >>> shamt);
      ALU_OR:   y = a | b;
      ALU_AND:  y = a & b;
      ALU_PASS: y = b;
      default:  y = '0;
    endcase
  end

endmodule

/* src/npc_core.sv */
`timescale 1ns/1ps

module npc_core (
  input  logic             clk,
  input  logic             rst,
  output npc_pkg::word_t   imem_addr,
  input  npc_pkg::word_t   imem_data,
  output logic             retire_valid,
  output npc_pkg::retire_t retire,
  output logic             halt
);
  import npc_pkg::*;

  word_t    inst, imm, pc, next_pc;
  word_t    src1, src2, csr_rdata, mtvec, mepc;
  word_t    op2, alu_result, mem_rdata, wb_data;
  reg_idx_t rs1, rs2, rd;
  logic [2:0] funct3;
  ctrl_t    ctrl;
  logic     halted;
  logic     commit;  // this cycle's instruction updates state

  assign inst      = imem_data;
  assign imem_addr = pc;
  assign commit    = !rst && !halted;

  always_ff @(posedge clk) begin
    if (rst) halted <= 1'b0;
    else if (commit && ctrl.is_ebreak) halted <= 1'b1;
  end

  always_comb begin
    case (ctrl.op2_sel)
      OP2_IMM: op2 = imm;
      OP2_CSR: op2 = csr_rdata;
      default: op2 = src2;
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      WB_PC4:    wb_data = pc + 32'd4;
      WB_MEM:    wb_data = mem_rdata;
      WB_CSR:    wb_data = csr_rdata;  // old csr value
      WB_PC_IMM: wb_data = pc + imm;
      default:   wb_data = alu_result;
    endcase
  end

  npc_fetch fetch_i (
    .clk       (clk),
    .rst       (rst),
    .halted    (halted),
    .ctrl      (ctrl),
    .imm       (imm),
    .src1      (src1),
    .src2      (src2),
    .alu_result(alu_result),
    .mtvec     (mtvec),
    .mepc      (mepc),
    .funct3    (funct3),
    .pc        (pc),
    .next_pc   (next_pc)
  );

  npc_decode decode_i (
    .inst  (inst),
    .imm   (imm),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .funct3(funct3),
    .ctrl  (ctrl)
  );

  npc_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .reg_wen  (ctrl.reg_wen && commit),
    .rd_data  (wb_data),
    .csr_addr (imm[11:0]),
    .csr_wen  (ctrl.csr_wen && commit),
    .csr_wdata(alu_result),
    .trap     (ctrl.is_ecall && commit),
    .trap_pc  (pc),
    .src1     (src1),
    .src2     (src2),
    .csr_rdata(csr_rdata),
    .mtvec    (mtvec),
    .mepc     (mepc)
  );

  npc_alu alu_i (
    .op(ctrl.alu_op),
    .a (src1),
    .b (op2),
    .y (alu_result)
  );

  npc_dmem dmem_i (
    .clk  (clk),
    .ren  (ctrl.mem_ren),
    .wen  (ctrl.mem_wen && commit),
    .size (ctrl.mem_size),
    .sext (ctrl.mem_sext),
    .addr (alu_result),
    .wdata(src2),
    .rdata(mem_rdata)
  );

  assign retire_valid    = commit;
  assign retire.pc       = pc;
  assign retire.inst     = inst;
  assign retire.rd_wen   = ctrl.reg_wen;
  assign retire.rd       = rd;
  assign retire.rd_data  = wb_data;
  assign retire.next_pc  = next_pc;
  assign halt            = halted;

endmodule

/* src/npc_decode.sv */
`timescale 1ns/1ps

module npc_decode (
  input  npc_pkg::word_t    inst,
  output npc_pkg::word_t    imm,
  output npc_pkg::reg_idx_t rs1,
  output npc_pkg::reg_idx_t rs2,
  output npc_pkg::reg_idx_t rd,
  output logic [2:0]        funct3,
  output npc_pkg::ctrl_t    ctrl
);
  import npc_pkg::*;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [6:0] opcode;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_e    arith_op;
  logic       alt;  // funct7 bit 5 selects sub / sra

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rd     = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // sub only exists in the register form, srai shares the bit with sra
  assign alt = inst[30] && (opcode == OPC_OP || funct3 == 3'b101);

  always_comb begin
    case (funct3)
      3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl = '0;  // add, reg operand, sequential, no writes
    imm  = imm_i;
    rs2  = inst[24:20];
    case (opcode)
      OPC_LUI: begin
        imm = imm_u;
        ctrl.alu_op  = ALU_PASS;
        ctrl.op2_sel = OP2_IMM;
        ctrl.reg_wen = 1'b1;
      end
      OPC_AUIPC: begin
        imm = imm_u;
        ctrl.wb_sel  = WB_PC_IMM;
        ctrl.reg_wen = 1'b1;
      end
      OPC_JAL: begin
        imm = imm_j;
        ctrl.npc_sel = NPC_PC_IMM;
        ctrl.wb_sel  = WB_PC4;
        ctrl.reg_wen = 1'b1;
      end
      OPC_JALR: begin
        ctrl.op2_sel = OP2_IMM;
        ctrl.npc_sel = NPC_JALR;
        ctrl.wb_sel  = WB_PC4;
        ctrl.reg_wen = 1'b1;
      end
      OPC_BRANCH: begin
        imm = imm_b;
        ctrl.npc_sel = NPC_BRANCH;
      end
      OPC_LOAD: begin
        ctrl.op2_sel  = OP2_IMM;
        ctrl.wb_sel   = WB_MEM;
        ctrl.reg_wen  = 1'b1;
        ctrl.mem_ren  = 1'b1;
        ctrl.mem_size = mem_size_e'(funct3[1:0]);
        ctrl.mem_sext = !funct3[2];
      end
      OPC_STORE: begin
        imm = imm_s;
        ctrl.op2_sel  = OP2_IMM;
        ctrl.mem_wen  = 1'b1;
        ctrl.mem_size = mem_size_e'(funct3[1:0]);
      end
      OPC_OP_IMM: begin
        ctrl.alu_op  = arith_op;
        ctrl.op2_sel = OP2_IMM;
        ctrl.reg_wen = 1'b1;
      end
      OPC_OP: begin
        ctrl.alu_op  = arith_op;
        ctrl.reg_wen = 1'b1;
      end
      OPC_SYSTEM: begin
        case (funct3)
          3'b000: begin
            if (inst[31:20] == 12'h000) begin
              ctrl.is_ecall = 1'b1;
              ctrl.npc_sel  = NPC_MTVEC;
            end else if (inst[31:20] == 12'h001) begin
              ctrl.is_ebreak = 1'b1;
            end else if (inst[31:20] == 12'h302) begin
              ctrl.npc_sel = NPC_MEPC;  // mret
            end
          end
          3'b001: begin
            // csrrw: rs2 port reads x[rs1] so pass moves it to the csr
            rs2 = inst[19:15];
            ctrl.alu_op  = ALU_PASS;
            ctrl.wb_sel  = WB_CSR;
            ctrl.reg_wen = 1'b1;
            ctrl.csr_wen = 1'b1;
          end
          3'b010: begin
            ctrl.alu_op  = ALU_OR;
            ctrl.op2_sel = OP2_CSR;
            ctrl.wb_sel  = WB_CSR;
            ctrl.reg_wen = 1'b1;
            ctrl.csr_wen = 1'b1;
          end
          default: ;
        endcase
      end
      default: ;  // unknown opcode retires as nop
    endcase
  end

endmodule

/* src/npc_dmem.sv */
`timescale 1ns/1ps
`include "npc_macros.svh"

module npc_dmem (
  input  logic                clk,
  input  logic                ren,
  input  logic                wen,
  input  npc_pkg::mem_size_e  size,
  input  logic                sext,
  input  npc_pkg::word_t      addr,
  input  npc_pkg::word_t      wdata,
  output npc_pkg::word_t      rdata
);
  import npc_pkg::*;

  localparam int AW = $clog2(`NPC_DMEM_BYTES);

  logic [7:0]    mem [`NPC_DMEM_BYTES];
  logic [AW-1:0] idx0, idx1, idx2, idx3;
  word_t         raw;

  // byte lanes wrap around the end of the array
  assign idx0 = addr[AW-1:0];
  assign idx1 = idx0 + AW'(1);
  assign idx2 = idx0 + AW'(2);
  assign idx3 = idx0 + AW'(3);

  assign raw = {mem[idx3], mem[idx2], mem[idx1], mem[idx0]};  // little endian

  always_comb begin
    if (!ren) begin
      rdata = '0;
    end else begin
      case (size)
        MEM_BYTE: rdata = {{24{sext && raw[7]}}, raw[7:0]};
        MEM_HALF: rdata = {{16{sext && raw[15]}}, raw[15:0]};
        default:  rdata = raw;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[idx0] <= wdata[7:0];
      if (size != MEM_BYTE) mem[idx1] <= wdata[15:8];
      if (size != MEM_BYTE && size != MEM_HALF) begin
        mem[idx2] <= wdata[23:16];
        mem[idx3] <= wdata[31:24];
      end
    end
  end

endmodule

/* src/npc_fetch.sv */
`timescale 1ns/1ps
`include "npc_macros.svh"

module npc_fetch (
  input  logic           clk,
  input  logic           rst,
  input  logic           halted,
  input  npc_pkg::ctrl_t ctrl,
  input  npc_pkg::word_t imm,
  input  npc_pkg::word_t src1,
  input  npc_pkg::word_t src2,
  input  npc_pkg::word_t alu_result,
  input  npc_pkg::word_t mtvec,
  input  npc_pkg::word_t mepc,
  input  logic [2:0]     funct3,
  output npc_pkg::word_t pc,
  output npc_pkg::word_t next_pc
);
  import npc_pkg::*;

  word_t pc_plus4, pc_plus_imm, jalr_target;
  logic  taken;

  assign pc_plus4    = pc + 32'd4;
  assign pc_plus_imm = pc + imm;
  assign jalr_target = alu_result & ~32'd1;

  always_comb begin
    case (funct3)
      3'b000:  taken = (src1 == src2);  // beq
      3'b001:  taken = (src1 != src2);
      3'b100:  taken = ($signed(src1) < $signed(src2));
      3'b101:  taken = ($signed(src1) >= $signed(src2));
      3'b110:  taken = (src1 < src2);   // bltu
      3'b111:  taken = (src1 >= src2);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (ctrl.npc_sel)
      NPC_PC_IMM: next_pc = pc_plus_imm;
      NPC_JALR:   next_pc = jalr_target;
      NPC_BRANCH: next_pc = taken ? pc_plus_imm : pc_plus4;
      NPC_MTVEC:  next_pc = mtvec;
      NPC_MEPC:   next_pc = mepc;
      default:    next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) pc <= `NPC_RESET_PC;
    else if (!halted) pc <= next_pc;  // frozen once halted
  end

endmodule

/* src/npc_macros.svh */
`ifndef NPC_MACROS_SVH
`define NPC_MACROS_SVH

// first fetch address after reset
`define NPC_RESET_PC 32'h8000_0000

// data ram size in bytes, addresses wrap modulo this
`define NPC_DMEM_BYTES 1024

`define NPC_CSR_MSTATUS 12'h300
`define NPC_CSR_MTVEC   12'h305
`define NPC_CSR_MEPC    12'h341
`define NPC_CSR_MCAUSE  12'h342

`endif

/* src/npc_pkg.sv */
package npc_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS  // y = b
  } alu_op_e;

  typedef enum logic [1:0] {OP2_REG, OP2_IMM, OP2_CSR} op2_sel_e;

  typedef enum logic [2:0] {
    NPC_SEQ,
    NPC_PC_IMM,
    NPC_JALR,
    NPC_BRANCH,
    NPC_MTVEC,
    NPC_MEPC
  } npc_sel_e;

  // pc plus imm is the auipc result
  typedef enum logic [2:0] {WB_ALU, WB_PC4, WB_MEM, WB_CSR, WB_PC_IMM} wb_sel_e;

  // encoding matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

  typedef struct packed {
    alu_op_e   alu_op;
    op2_sel_e  op2_sel;
    npc_sel_e  npc_sel;
    wb_sel_e   wb_sel;
    logic      reg_wen;
    logic      mem_ren;
    logic      mem_wen;
    mem_size_e mem_size;
    logic      mem_sext;
    logic      csr_wen;
    logic      is_ecall;
    logic      is_ebreak;
  } ctrl_t;

  typedef struct packed {
    word_t    pc;
    word_t    inst;
    logic     rd_wen;
    reg_idx_t rd;
    word_t    rd_data;
    word_t    next_pc;
  } retire_t;

endpackage

/* src/npc_regfile.sv */
`timescale 1ns/1ps
`include "npc_macros.svh"

module npc_regfile (
  input  logic              clk,
  input  logic              rst,
  input  npc_pkg::reg_idx_t rs1,
  input  npc_pkg::reg_idx_t rs2,
  input  npc_pkg::reg_idx_t rd,
  input  logic              reg_wen,
  input  npc_pkg::word_t    rd_data,
  input  logic [11:0]       csr_addr,
  input  logic              csr_wen,
  input  npc_pkg::word_t    csr_wdata,
  input  logic              trap,
  input  npc_pkg::word_t    trap_pc,
  output npc_pkg::word_t    src1,
  output npc_pkg::word_t    src2,
  output npc_pkg::word_t    csr_rdata,
  output npc_pkg::word_t    mtvec,
  output npc_pkg::word_t    mepc
);
  import npc_pkg::*;

  word_t gpr [32];
  word_t mstatus, mcause;

  assign src1 = (rs1 == '0) ? '0 : gpr[rs1];
  assign src2 = (rs2 == '0) ? '0 : gpr[rs2];

  always_comb begin
    case (csr_addr)
      `NPC_CSR_MSTATUS: csr_rdata = mstatus;
      `NPC_CSR_MTVEC:   csr_rdata = mtvec;
      `NPC_CSR_MEPC:    csr_rdata = mepc;
      `NPC_CSR_MCAUSE:  csr_rdata = mcause;
      default:          csr_rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) gpr[i] <= '0;
    end else if (reg_wen && rd != '0) begin
      gpr[rd] <= rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (csr_wen) begin
        case (csr_addr)
          `NPC_CSR_MSTATUS: mstatus <= csr_wdata;
          `NPC_CSR_MTVEC:   mtvec   <= csr_wdata;
          `NPC_CSR_MEPC:    mepc    <= csr_wdata;
          `NPC_CSR_MCAUSE:  mcause  <= csr_wdata;
          default: ;
        endcase
      end
      if (trap) begin
        mepc   <= trap_pc;
        mcause <= 32'd11;  // ecall from m-mode
      end
    end
  end

endmodule
